/* source/link_pkg.sv */
`default_nettype none

package link_pkg;

	// error code shown on the first digit, so it fits a nibble
	typedef enum logic [3:0] {
		ERR_NONE     = 4'd0,
		ERR_CHECK    = 4'd1,
		ERR_SEQUENCE = 4'd2
	} link_err_t;

	// width of the counting data word
	localparam int DEFAULT_DATA_W = 8;

	// 10 ms of stable input at 25 MHz
	localparam int DEFAULT_DEBOUNCE_CYCLES = 250000;

endpackage

`default_nettype wire

/* source/switch_debouncer.sv */
`default_nettype none

module switch_debouncer import link_pkg::*; #(
	parameter int DEBOUNCE_CYCLES = DEFAULT_DEBOUNCE_CYCLES
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_switch,
	output logic o_level,
	output logic o_press
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic             sync_1;
	logic             sync_2;
	logic [CNT_W-1:0] stable_cnt;
	logic             level_d;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			sync_1     <= 1'b0;
			sync_2     <= 1'b0;
			stable_cnt <= '0;
			o_level    <= 1'b0;
			level_d    <= 1'b0;
		end else begin
			sync_1  <= i_switch;
			sync_2  <= sync_1;
			level_d <= o_level;
			// count how long the synced input has differed from the level
			if (sync_2 == o_level) begin
				stable_cnt <= '0;
			end else if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
				stable_cnt <= '0;
				o_level    <= sync_2;
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

	assign o_press = o_level & ~level_d;

endmodule

`default_nettype wire

/* source/probe_source.sv */
`default_nettype none

module probe_source import link_pkg::*; #(
	parameter int DATA_W = DEFAULT_DATA_W
) (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_inject_check,
	input  logic              i_inject_skip,
	output logic              o_msg_valid,
	output logic [DATA_W-1:0] o_msg_data,
	output logic [DATA_W-1:0] o_msg_check,
	input  logic              i_msg_ready
);

	logic              xfer;
	logic              pend_check;
	logic              pend_skip;
	logic              apply_check;
	logic              apply_skip;
	logic [DATA_W-1:0] next_data;

	assign xfer = o_msg_valid & i_msg_ready;

	// a request in the transfer cycle still hits the next message
	assign apply_check = pend_check | i_inject_check;
	assign apply_skip  = pend_skip | i_inject_skip;

	// skip adds one more step to the counter
	assign next_data = o_msg_data + DATA_W'(1) + DATA_W'(apply_skip);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_msg_valid <= 1'b0;
			o_msg_data  <= DATA_W'(1);
			o_msg_check <= ~DATA_W'(1);
			pend_check  <= 1'b0;
			pend_skip   <= 1'b0;
		end else begin
			o_msg_valid <= 1'b1;
			if (xfer) begin
				o_msg_data <= next_data;
				// corrupt only the low bit of the check word
				o_msg_check <= ~next_data ^ DATA_W'(apply_check);
				pend_check  <= 1'b0;
				pend_skip   <= 1'b0;
			end else begin
				pend_check <= apply_check;
				pend_skip  <= apply_skip;
			end
		end
	end

endmodule

`default_nettype wire

/* source/probe_sink.sv */
`default_nettype none

module probe_sink import link_pkg::*; #(
	parameter int DATA_W    = DEFAULT_DATA_W,
	parameter int SINK_PACE = 2
) (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_freeze,
	input  logic              i_msg_valid,
	input  logic [DATA_W-1:0] i_msg_data,
	input  logic [DATA_W-1:0] i_msg_check,
	output logic              o_msg_ready,
	output logic [DATA_W-1:0] o_last_data,
	output link_err_t         o_err_code,
	output logic              o_err
);

	localparam int PACE_W = (SINK_PACE > 0) ? $clog2(SINK_PACE + 1) : 1;

	logic              running;
	logic [PACE_W-1:0] pace_cnt;
	logic              xfer;
	logic [DATA_W-1:0] expected;
	logic              check_bad;
	logic              seq_bad;

	// held low until the first cycle out of reset
	assign o_msg_ready = running & ~i_freeze & (pace_cnt == '0);
	assign xfer        = i_msg_valid & o_msg_ready;

	assign check_bad = (i_msg_check != ~i_msg_data);
	assign seq_bad   = (i_msg_data != expected);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			running  <= 1'b0;
			pace_cnt <= '0;
		end else begin
			running <= 1'b1;
			if (xfer) begin
				pace_cnt <= PACE_W'(SINK_PACE);
			end else if (pace_cnt != '0) begin
				pace_cnt <= pace_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			expected    <= DATA_W'(1);
			o_last_data <= '0;
			o_err_code  <= ERR_NONE;
		end else if (xfer) begin
			o_last_data <= i_msg_data;
			// resync on whatever arrived
			expected <= i_msg_data + DATA_W'(1);
			// first fault sticks, check fault wins a tie
			if (o_err_code == ERR_NONE) begin
				if (check_bad) begin
					o_err_code <= ERR_CHECK;
				end else if (seq_bad) begin
					o_err_code <= ERR_SEQUENCE;
				end
			end
		end
	end

	assign o_err = (o_err_code != ERR_NONE);

endmodule

`default_nettype wire

/* source/seven_seg_decoder.sv */
`default_nettype none

module seven_seg_decoder (
	input  logic       i_clk,
	input  logic [3:0] i_nibble,
	output logic [6:0] o_segments
);

	// patterns are g..a, lit high, then inverted for common anode
	always_ff @(posedge i_clk) begin
		case (i_nibble)
			4'h0: o_segments <= ~7'h3f;
			4'h1: o_segments <= ~7'h06;
			4'h2: o_segments <= ~7'h5b;
			4'h3: o_segments <= ~7'h4f;
			4'h4: o_segments <= ~7'h66;
			4'h5: o_segments <= ~7'h6d;
			4'h6: o_segments <= ~7'h7d;
			4'h7: o_segments <= ~7'h07;
			4'h8: o_segments <= ~7'h7f;
			4'h9: o_segments <= ~7'h6f;
			4'ha: o_segments <= ~7'h77;
			4'hb: o_segments <= ~7'h7c;
			4'hc: o_segments <= ~7'h39;
			4'hd: o_segments <= ~7'h5e;
			4'he: o_segments <= ~7'h79;
			default: o_segments <= ~7'h71;
		endcase
	end

endmodule

`default_nettype wire

/* source/link_test_top.sv */
`default_nettype none

module link_test_top import link_pkg::*; #(
	parameter int DATA_W          = DEFAULT_DATA_W,
	parameter int DEBOUNCE_CYCLES = DEFAULT_DEBOUNCE_CYCLES,
	parameter int SINK_PACE       = 2
) (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_switch_1,
	input  logic       i_switch_2,
	input  logic       i_switch_3,
	output logic [6:0] o_segment1,
	output logic [6:0] o_segment2,
	output logic       o_led_1
);

	logic              freeze;
	logic              inject_check;
	logic              inject_skip;
	logic              msg_valid;
	logic              msg_ready;
	logic [DATA_W-1:0] msg_data;
	logic [DATA_W-1:0] msg_check;
	logic [DATA_W-1:0] last_data;
	link_err_t         err_code;

	// switch 1 is used as a level, 2 and 3 as presses
	switch_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) sw1_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_switch(i_switch_1),
		.o_level (freeze),
		.o_press ()
	);

	switch_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) sw2_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_switch(i_switch_2),
		.o_level (),
		.o_press (inject_check)
	);

	switch_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) sw3_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_switch(i_switch_3),
		.o_level (),
		.o_press (inject_skip)
	);

	probe_source #(.DATA_W(DATA_W)) src_i (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_inject_check(inject_check),
		.i_inject_skip (inject_skip),
		.o_msg_valid   (msg_valid),
		.o_msg_data    (msg_data),
		.o_msg_check   (msg_check),
		.i_msg_ready   (msg_ready)
	);

	probe_sink #(.DATA_W(DATA_W), .SINK_PACE(SINK_PACE)) sink_i (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_freeze   (freeze),
		.i_msg_valid(msg_valid),
		.i_msg_data (msg_data),
		.i_msg_check(msg_check),
		.o_msg_ready(msg_ready),
		.o_last_data(last_data),
		.o_err_code (err_code),
		.o_err      (o_led_1)
	);

	// digit 1 error code, digit 2 low nibble of last data
	seven_seg_decoder disp1_i (
		.i_clk     (i_clk),
		.i_nibble  (err_code),
		.o_segments(o_segment1)
	);

	seven_seg_decoder disp2_i (
		.i_clk     (i_clk),
		.i_nibble  (last_data[3:0]),
		.o_segments(o_segment2)
	);

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 5
) (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD / 2) o_clk = ~o_clk;
	end

	// power-on reset is released on a rising edge
	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* testbench/link_test_asserts.sv */
`default_nettype none

module link_test_asserts #(
	parameter int DATA_W = 8
) (
	input logic              i_clk,
	input logic              i_rst_n,
	input logic              i_msg_valid,
	input logic [DATA_W-1:0] i_msg_data,
	input logic [DATA_W-1:0] i_msg_check,
	input logic              i_msg_ready
);

	// assertion failures seen so far
	int fail_count = 0;

	// a presented message stays until it is taken
	valid_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_msg_valid && !i_msg_ready) |=> i_msg_valid)
	else begin
		fail_count++;
		$error("link valid fell without a transfer");
	end

	payload_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_msg_valid && !i_msg_ready) |=> ($stable(i_msg_data) && $stable(i_msg_check)))
	else begin
		fail_count++;
		$error("link data or check changed under back-pressure");
	end

	valid_low_in_reset: assert property (@(posedge i_clk) !i_rst_n |=> !i_msg_valid)
	else begin
		fail_count++;
		$error("link valid high during reset");
	end

endmodule

bind probe_source link_test_asserts #(.DATA_W(DATA_W)) link_asserts_i (
	.i_clk      (i_clk),
	.i_rst_n    (i_rst_n),
	.i_msg_valid(o_msg_valid),
	.i_msg_data (o_msg_data),
	.i_msg_check(o_msg_check),
	.i_msg_ready(i_msg_ready)
);

`default_nettype wire

/* testbench/link_test_tb.sv */
`default_nettype none

module link_test_tb import link_pkg::*; ();

	localparam int DEBOUNCE        = 4;
	localparam int RESET_CYCLES    = 5;
	localparam int MARGIN          = 20;
	localparam int HOLD_CYCLES     = 10;
	localparam int NUM_TESTS       = 6;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 2000;

	// lit-high patterns, g..a, for hex digits 0..f
	localparam logic [6:0] SEG_LIT [16] = '{
		7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111,
		7'b1100110, 7'b1101101, 7'b1111101, 7'b0000111,
		7'b1111111, 7'b1101111, 7'b1110111, 7'b1111100,
		7'b0111001, 7'b1011110, 7'b1111001, 7'b1110001
	};

	logic       clk;
	logic       por_rst_n;
	logic       test_rst_n;
	logic       rst_n;
	logic       sw_1;
	logic       sw_2;
	logic       sw_3;
	logic [6:0] o_segment1;
	logic [6:0] o_segment2;
	logic       o_led_1;
	int         mismatches = 0;
	int         failures   = 0;
	int         assert_fails;

	assign rst_n = por_rst_n & test_rst_n;

	tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(RESET_CYCLES)) clk_gen_i (
		.o_clk  (clk),
		.o_rst_n(por_rst_n)
	);

	link_test_top #(.DEBOUNCE_CYCLES(DEBOUNCE)) dut_i (
		.i_clk     (clk),
		.i_rst_n   (rst_n),
		.i_switch_1(sw_1),
		.i_switch_2(sw_2),
		.i_switch_3(sw_3),
		.o_segment1(o_segment1),
		.o_segment2(o_segment2),
		.o_led_1   (o_led_1)
	);

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	// ends on the falling edge right after release
	task automatic pulse_reset();
		@(posedge clk);
		test_rst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		test_rst_n <= 1'b1;
		@(negedge clk);
	endtask

	task automatic drive_switch(input int idx, input logic value);
		@(posedge clk);
		case (idx)
			1: sw_1 <= value;
			2: sw_2 <= value;
			default: sw_3 <= value;
		endcase
	endtask

	task automatic press_switch(input int idx);
		drive_switch(idx, 1'b1);
		wait_cycles(HOLD_CYCLES);
		drive_switch(idx, 1'b0);
		wait_cycles(MARGIN);
		@(negedge clk);
	endtask

	function automatic int hex_on_digit(input logic [6:0] seg);
		int found;
		found = -1;
		for (int i = 0; i < 16; i++) begin
			if (seg === ~SEG_LIT[i]) found = i;
		end
		return found;
	endfunction

	task automatic check_digit(input string test, input int digit, input logic [6:0] actual,
		input logic [3:0] expected);
		if (actual !== ~SEG_LIT[expected]) begin
			mismatches++;
			$display("Mismatch %s digit %0d: expected %h (%b) actual %b", test, digit,
				expected, ~SEG_LIT[expected], actual);
		end
	endtask

	task automatic check_led(input string test, input logic expected);
		if (o_led_1 !== expected) begin
			mismatches++;
			$display("Mismatch %s led: expected %b actual %b", test, expected, o_led_1);
		end
	endtask

	task automatic reset_state_test();
		pulse_reset();
		check_led("reset_state", 1'b0);
		check_digit("reset_state", 1, o_segment1, 4'h0);
		check_digit("reset_state", 2, o_segment2, 4'h0);
		wait_cycles(200);
		@(negedge clk);
		check_led("reset_state", 1'b0);
		check_digit("reset_state", 1, o_segment1, 4'h0);
	endtask

	task automatic freeze_test();
		int held;
		int later;
		pulse_reset();
		wait_cycles(MARGIN);
		drive_switch(1, 1'b1);
		wait_cycles(MARGIN);
		@(negedge clk);
		held = hex_on_digit(o_segment2);
		if (held < 0) begin
			failures++;
			$display("freeze: digit 2 shows no hex digit while frozen (%b)", o_segment2);
		end
		wait_cycles(200);
		@(negedge clk);
		check_digit("freeze", 2, o_segment2, held[3:0]);
		drive_switch(1, 1'b0);
		wait_cycles(300);
		drive_switch(1, 1'b1);
		wait_cycles(MARGIN);
		@(negedge clk);
		later = hex_on_digit(o_segment2);
		if (later == held) begin
			failures++;
			$display("freeze: digit 2 did not move while the sink ran");
		end
		check_led("freeze", 1'b0);
		drive_switch(1, 1'b0);
		wait_cycles(MARGIN);
	endtask

	task automatic check_fault_test();
		pulse_reset();
		wait_cycles(MARGIN);
		press_switch(2);
		check_led("check_fault", 1'b1);
		check_digit("check_fault", 1, o_segment1, 4'(ERR_CHECK));
	endtask

	task automatic sequence_fault_test();
		pulse_reset();
		wait_cycles(MARGIN);
		press_switch(3);
		check_led("sequence_fault", 1'b1);
		check_digit("sequence_fault", 1, o_segment1, 4'(ERR_SEQUENCE));
	endtask

	task automatic sticky_error_test();
		pulse_reset();
		wait_cycles(MARGIN);
		press_switch(2);
		press_switch(3);
		check_led("sticky_error", 1'b1);
		check_digit("sticky_error", 1, o_segment1, 4'(ERR_CHECK));
		// only reset clears the code
		pulse_reset();
		check_led("sticky_error", 1'b0);
		check_digit("sticky_error", 1, o_segment1, 4'h0);
	endtask

	task automatic short_pulse_test();
		pulse_reset();
		wait_cycles(MARGIN);
		drive_switch(2, 1'b1);
		wait_cycles(1);
		drive_switch(2, 1'b0);
		wait_cycles(MARGIN * 5);
		@(negedge clk);
		check_led("short_pulse", 1'b0);
		check_digit("short_pulse", 1, o_segment1, 4'h0);
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		sw_1       = 1'b0;
		sw_2       = 1'b0;
		sw_3       = 1'b0;
		test_rst_n = 1'b1;
		wait (por_rst_n === 1'b1);
		reset_state_test();
		freeze_test();
		check_fault_test();
		sequence_fault_test();
		sticky_error_test();
		short_pulse_test();
		assert_fails = dut_i.src_i.link_asserts_i.fail_count;
		$display("summary: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatches, failures, assert_fails);
		if (mismatches == 0 && failures == 0 && assert_fails == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
source/link_pkg.sv
source/switch_debouncer.sv
source/probe_source.sv
source/probe_sink.sv
source/seven_seg_decoder.sv
source/link_test_top.sv
testbench/tb_clock_gen.sv
testbench/link_test_asserts.sv
testbench/link_test_tb.sv
